//--- soc_pkg.sv
package soc_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [7:0]        char_t;  // One console character

    localparam addr_t UART_BASE_DEF  = 32'h1000_0000;
    localparam addr_t CLINT_BASE_DEF = 32'h0200_0000;

    // Low address bits that stay inside one peripheral region
    localparam int unsigned REGION_BITS = 16;

    localparam logic [REGION_BITS-1:0] UART_TX      = 16'h0000;
    localparam logic [REGION_BITS-1:0] UART_RX      = 16'h0004;
    localparam logic [REGION_BITS-1:0] UART_CNT     = 16'h0008;
    localparam logic [REGION_BITS-1:0] UART_SCRATCH = 16'h000C;

    localparam logic [REGION_BITS-1:0] CLINT_MSIP    = 16'h0000;
    localparam logic [REGION_BITS-1:0] CLINT_CMP_LO  = 16'h4000;
    localparam logic [REGION_BITS-1:0] CLINT_CMP_HI  = 16'h4004;
    localparam logic [REGION_BITS-1:0] CLINT_TIME_LO = 16'hBFF8;
    localparam logic [REGION_BITS-1:0] CLINT_TIME_HI = 16'hBFFC;

    typedef enum logic {
        BUS_IDLE,
        BUS_RESP
    } bus_state_t;

endpackage

//--- wb_if.sv
`timescale 1ns/10ps

interface wb_if;
    import soc_pkg::*;

    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat_w;
    data_t dat_r;  // Valid while ack is high
    logic  ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

//--- periph_bus.sv
`timescale 1ns/10ps

module periph_bus #(
    parameter soc_pkg::addr_t UART_BASE  = soc_pkg::UART_BASE_DEF,
    parameter soc_pkg::addr_t CLINT_BASE = soc_pkg::CLINT_BASE_DEF
) (
    input  logic            clock,
    input  logic            rst_i,
    input  logic            wb_cyc_i,
    input  logic            wb_stb_i,
    input  logic            wb_we_i,
    input  soc_pkg::addr_t  wb_adr_i,
    input  soc_pkg::data_t  wb_dat_i,
    output soc_pkg::data_t  wb_dat_o,
    output logic            wb_ack_o,
    output logic            wb_err_o,
    wb_if.master            uart_m,
    wb_if.master            clint_m
);
    import soc_pkg::*;

    logic       uart_hit;
    logic       clint_hit;
    logic       miss_req;
    bus_state_t state;

    // Region match on the bits above the region offset
    assign uart_hit  = wb_adr_i[ADDR_W-1:REGION_BITS] == UART_BASE[ADDR_W-1:REGION_BITS];
    assign clint_hit = wb_adr_i[ADDR_W-1:REGION_BITS] == CLINT_BASE[ADDR_W-1:REGION_BITS];
    assign miss_req  = wb_cyc_i && wb_stb_i && !uart_hit && !clint_hit;

    assign uart_m.cyc   = wb_cyc_i && uart_hit;
    assign uart_m.stb   = wb_stb_i && uart_hit;
    assign uart_m.we    = wb_we_i;
    assign uart_m.adr   = wb_adr_i;
    assign uart_m.dat_w = wb_dat_i;

    assign clint_m.cyc   = wb_cyc_i && clint_hit;
    assign clint_m.stb   = wb_stb_i && clint_hit;
    assign clint_m.we    = wb_we_i;
    assign clint_m.adr   = wb_adr_i;
    assign clint_m.dat_w = wb_dat_i;

    // Unmapped access gets a one-cycle error
    always_ff @(posedge clock) begin
        if (rst_i) begin
            state <= BUS_IDLE;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (miss_req) begin
                        state <= BUS_RESP;
                    end
                end
                BUS_RESP: state <= BUS_IDLE;
                default:  state <= BUS_IDLE;
            endcase
        end
    end

    assign wb_err_o = (state == BUS_RESP);

    always_comb begin
        wb_ack_o = 1'b0;
        wb_dat_o = '0;  // Zero for unmapped reads
        if (uart_hit) begin
            wb_ack_o = uart_m.ack;
            wb_dat_o = uart_m.dat_r;
        end else if (clint_hit) begin
            wb_ack_o = clint_m.ack;
            wb_dat_o = clint_m.dat_r;
        end
    end

endmodule

//--- sim_uart.sv
`timescale 1ns/10ps

module sim_uart (
    input  logic            clock,
    input  logic            rst_i,
    wb_if.slave             bus_s,
    output logic            uart_out_valid_o,
    output soc_pkg::char_t  uart_out_ch_o,
    output logic            uart_in_valid_o,
    input  soc_pkg::char_t  uart_in_ch_i
);
    import soc_pkg::*;

    logic                   ack;
    logic                   req;
    logic                   wr_en;
    logic [REGION_BITS-1:0] offset;
    data_t                  tx_cnt;
    data_t                  scratch;
    data_t                  rd_data;

    assign req    = bus_s.cyc && bus_s.stb && !ack;  // New access this cycle
    assign wr_en  = req && bus_s.we;
    assign offset = bus_s.adr[REGION_BITS-1:0];

    always_ff @(posedge clock) begin
        if (rst_i) begin
            ack              <= 1'b0;
            tx_cnt           <= '0;
            uart_out_valid_o <= 1'b0;
            uart_in_valid_o  <= 1'b0;
        end else begin
            ack              <= req;
            uart_out_valid_o <= wr_en && (offset == UART_TX);
            uart_in_valid_o  <= req && !bus_s.we && (offset == UART_RX);  // Host fetch
            if (wr_en && (offset == UART_TX)) begin
                tx_cnt <= tx_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en && (offset == UART_TX)) begin
            uart_out_ch_o <= bus_s.dat_w[7:0];
        end
        if (wr_en && (offset == UART_SCRATCH)) begin
            scratch <= bus_s.dat_w;
        end
    end

    always_comb begin
        case (offset)
            UART_RX:      rd_data = data_t'(uart_in_ch_i);  // Sampled in the ack cycle
            UART_CNT:     rd_data = tx_cnt;
            UART_SCRATCH: rd_data = scratch;
            default:      rd_data = '0;
        endcase
    end

    assign bus_s.ack   = ack;
    assign bus_s.dat_r = rd_data;

endmodule

//--- clint_timer.sv
`timescale 1ns/10ps

module clint_timer (
    input  logic clock,
    input  logic rst_i,
    wb_if.slave  bus_s,
    output logic mtip_o,
    output logic msip_o
);
    import soc_pkg::*;

    typedef logic [63:0] mtime_t;

    logic                   ack;
    logic                   req;
    logic                   wr_en;
    logic [REGION_BITS-1:0] offset;
    mtime_t                 mtime;
    mtime_t                 mtimecmp;
    data_t                  rd_data;

    assign req    = bus_s.cyc && bus_s.stb && !ack;
    assign wr_en  = req && bus_s.we;
    assign offset = bus_s.adr[REGION_BITS-1:0];

    always_ff @(posedge clock) begin
        if (rst_i) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // Free-running machine timer
    always_ff @(posedge clock) begin
        if (rst_i) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst_i) begin
            mtimecmp <= '1;  // Interrupt off until programmed
            msip_o   <= 1'b0;
        end else if (wr_en) begin
            case (offset)
                CLINT_MSIP:   msip_o          <= bus_s.dat_w[0];
                CLINT_CMP_LO: mtimecmp[31:0]  <= bus_s.dat_w;
                CLINT_CMP_HI: mtimecmp[63:32] <= bus_s.dat_w;
                default:      ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst_i) begin
            mtip_o <= 1'b0;
        end else begin
            mtip_o <= (mtime >= mtimecmp);
        end
    end

    always_comb begin
        case (offset)
            CLINT_MSIP:    rd_data = data_t'(msip_o);
            CLINT_CMP_LO:  rd_data = mtimecmp[31:0];
            CLINT_CMP_HI:  rd_data = mtimecmp[63:32];
            CLINT_TIME_LO: rd_data = mtime[31:0];
            CLINT_TIME_HI: rd_data = mtime[63:32];
            default:       rd_data = '0;
        endcase
    end

    assign bus_s.ack   = ack;
    assign bus_s.dat_r = rd_data;

endmodule

//--- periph_top.sv
`timescale 1ns/10ps

module periph_top #(
    parameter soc_pkg::addr_t UART_BASE  = soc_pkg::UART_BASE_DEF,
    parameter soc_pkg::addr_t CLINT_BASE = soc_pkg::CLINT_BASE_DEF
) (
    input  logic            clock,
    input  logic            rst_i,
    input  logic            wb_cyc_i,
    input  logic            wb_stb_i,
    input  logic            wb_we_i,
    input  soc_pkg::addr_t  wb_adr_i,
    input  soc_pkg::data_t  wb_dat_i,
    output soc_pkg::data_t  wb_dat_o,
    output logic            wb_ack_o,
    output logic            wb_err_o,
    output logic            uart_out_valid_o,
    output soc_pkg::char_t  uart_out_ch_o,
    output logic            uart_in_valid_o,
    input  soc_pkg::char_t  uart_in_ch_i,
    output logic            mtip_o,
    output logic            msip_o
);

    wb_if uart_bus ();
    wb_if clint_bus ();

    periph_bus #(
        .UART_BASE  (UART_BASE),
        .CLINT_BASE (CLINT_BASE)
    ) bus (
        .clock    (clock),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o),
        .uart_m   (uart_bus.master),
        .clint_m  (clint_bus.master)
    );

    sim_uart uart (
        .clock            (clock),
        .rst_i            (rst_i),
        .bus_s            (uart_bus.slave),
        .uart_out_valid_o (uart_out_valid_o),
        .uart_out_ch_o    (uart_out_ch_o),
        .uart_in_valid_o  (uart_in_valid_o),
        .uart_in_ch_i     (uart_in_ch_i)
    );

    clint_timer clint (
        .clock  (clock),
        .rst_i  (rst_i),
        .bus_s  (clint_bus.slave),
        .mtip_o (mtip_o),
        .msip_o (msip_o)
    );

endmodule

//--- tb_periph_top.sv
`timescale 1ns/10ps

module tb_periph_top;

    localparam int          BUS_TIMEOUT = 20;
    localparam logic [31:0] TX_ADDR     = 32'h1000_0000;
    localparam logic [31:0] RX_ADDR     = 32'h1000_0004;

    logic        clock;
    logic        rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;
    logic        uart_out_valid_o;
    logic [7:0]  uart_out_ch_o;
    logic        uart_in_valid_o;
    logic [7:0]  uart_in_ch_i;
    logic        mtip_o;
    logic        msip_o;

    int          errors;
    int          checks;
    int          cases_run;
    int          out_pulses;
    int          in_pulses;
    logic [7:0]  out_char;
    logic [31:0] last_time;
    logic        have_time;

    periph_top dut (
        .clock            (clock),
        .rst_i            (rst_i),
        .wb_cyc_i         (wb_cyc_i),
        .wb_stb_i         (wb_stb_i),
        .wb_we_i          (wb_we_i),
        .wb_adr_i         (wb_adr_i),
        .wb_dat_i         (wb_dat_i),
        .wb_dat_o         (wb_dat_o),
        .wb_ack_o         (wb_ack_o),
        .wb_err_o         (wb_err_o),
        .uart_out_valid_o (uart_out_valid_o),
        .uart_out_ch_o    (uart_out_ch_o),
        .uart_in_valid_o  (uart_in_valid_o),
        .uart_in_ch_i     (uart_in_ch_i),
        .mtip_o           (mtip_o),
        .msip_o           (msip_o)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Host console monitor at mid-cycle
    always @(negedge clock) begin
        if (!rst_i) begin
            if (uart_out_valid_o) begin
                out_pulses = out_pulses + 1;
                out_char   = uart_out_ch_o;
            end
            if (uart_in_valid_o) begin
                in_pulses = in_pulses + 1;
            end
        end
    end

    // Entered and left 1 ns after a rising edge
    task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic got_ack,
                              output logic got_err);
        int   cycles;
        logic done;
        rdata    = '0;
        got_ack  = 1'b0;
        got_err  = 1'b0;
        done     = 1'b0;
        cycles   = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = addr;
        wb_dat_i = data;
        while (!done && cycles < BUS_TIMEOUT) begin
            @(negedge clock);
            cycles = cycles + 1;
            if (wb_ack_o || wb_err_o) begin
                done    = 1'b1;
                got_ack = wb_ack_o;
                got_err = wb_err_o;
                rdata   = wb_dat_o;
            end
        end
        if (!done) begin
            $display("Timeout at %0t: no ack or err within %0d cycles for address %h",
                     $time, BUS_TIMEOUT, addr);
            errors = errors + 1;
        end
        @(posedge clock);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge clock);  // Idle cycle between accesses
        #1;
    endtask

    task automatic run_case(input logic [3:0] op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] expv,
                            input logic [7:0] host, input logic [3:0] errf);
        logic [31:0] rdata;
        logic [31:0] data;
        logic        got_ack;
        logic        got_err;
        logic        is_access;
        logic        bad;
        int          out_before;
        int          in_before;
        int          exp_out;
        int          exp_in;
        int          cycles;
        out_before   = out_pulses;
        in_before    = in_pulses;
        exp_out      = 0;
        exp_in       = 0;
        is_access    = 1'b0;
        bad          = 1'b0;
        uart_in_ch_i = host;
        case (op)
            4'h0, 4'h4: begin
                data = (op == 4'h4) ? last_time + wdata : wdata;  // 4 is relative to time
                is_access = 1'b1;
                bus_access(1'b1, addr, data, rdata, got_ack, got_err);
                if (addr == TX_ADDR && !errf[0]) begin
                    exp_out = 1;
                end
            end
            4'h1, 4'h3: begin
                is_access = 1'b1;
                bus_access(1'b0, addr, 32'h0, rdata, got_ack, got_err);
                if (addr == RX_ADDR && !errf[0]) begin
                    exp_in = 1;
                end
                checks = checks + 1;
                if (op == 4'h1 && rdata !== expv) begin
                    $display("Error at %0t: read of %h returned %h, expected %h",
                             $time, addr, rdata, expv);
                    errors = errors + 1;
                end
                if (op == 4'h3) begin
                    if (have_time && rdata <= last_time) begin
                        $display("Error at %0t: timer read %h not above previous %h",
                                 $time, rdata, last_time);
                        errors = errors + 1;
                    end
                    last_time = rdata;
                    have_time = 1'b1;
                end
            end
            4'h2: begin
                cycles = 0;
                while (mtip_o !== expv[0] && cycles < wdata) begin
                    @(negedge clock);
                    cycles = cycles + 1;
                end
                checks = checks + 1;
                if (mtip_o !== expv[0]) begin
                    $display("Error at %0t: mtip_o did not reach %b within %0d cycles",
                             $time, expv[0], wdata);
                    errors = errors + 1;
                end
                @(posedge clock);
                #1;
            end
            4'h5: begin
                for (cycles = 0; cycles < wdata; cycles++) begin
                    @(negedge clock);
                    if (mtip_o !== expv[0] && !bad) begin
                        $display("Error at %0t: mtip_o is %b, expected to hold %b",
                                 $time, mtip_o, expv[0]);
                        errors = errors + 1;
                        bad = 1'b1;
                    end
                end
                checks = checks + 1;
                @(posedge clock);
                #1;
            end
            4'h6: begin
                checks = checks + 1;
                if (msip_o !== expv[0]) begin
                    $display("Error at %0t: msip_o is %b, expected %b",
                             $time, msip_o, expv[0]);
                    errors = errors + 1;
                end
            end
            default: begin
                $display("Unknown operation %h in the cases file", op);
                errors = errors + 1;
            end
        endcase
        if (is_access) begin
            checks = checks + 1;
            if (errf[0] && (!got_err || got_ack)) begin
                $display("Error at %0t: access to %h should end with err, got ack=%b err=%b",
                         $time, addr, got_ack, got_err);
                errors = errors + 1;
            end
            if (!errf[0] && (!got_ack || got_err)) begin
                $display("Error at %0t: access to %h should end with ack, got ack=%b err=%b",
                         $time, addr, got_ack, got_err);
                errors = errors + 1;
            end
        end
        checks = checks + 1;
        if (out_pulses - out_before != exp_out) begin
            $display("Error at %0t: %0d output strobes seen, expected %0d",
                     $time, out_pulses - out_before, exp_out);
            errors = errors + 1;
        end
        if (exp_out == 1 && out_char !== wdata[7:0]) begin
            $display("Error at %0t: output character %h, expected %h",
                     $time, out_char, wdata[7:0]);
            errors = errors + 1;
        end
        checks = checks + 1;
        if (in_pulses - in_before != exp_in) begin
            $display("Error at %0t: %0d input requests seen, expected %0d",
                     $time, in_pulses - in_before, exp_in);
            errors = errors + 1;
        end
    endtask

    initial begin
        int              fd;
        int              n;
        reg [8*160-1:0]  line_buf;
        logic [3:0]      op;
        logic [31:0]     addr;
        logic [31:0]     wdata;
        logic [31:0]     expv;
        logic [7:0]      host;
        logic [3:0]      errf;
        rst_i        = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        uart_in_ch_i = '0;
        errors       = 0;
        checks       = 0;
        cases_run    = 0;
        out_pulses   = 0;
        in_pulses    = 0;
        out_char     = '0;
        last_time    = '0;
        have_time    = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        rst_i = 1'b0;
        checks = checks + 1;
        if (wb_ack_o !== 1'b0 || wb_err_o !== 1'b0 || uart_out_valid_o !== 1'b0 ||
            uart_in_valid_o !== 1'b0 || mtip_o !== 1'b0 || msip_o !== 1'b0) begin
            $display("Error at %0t: outputs not inactive after reset", $time);
            errors = errors + 1;
        end
        fd = $fopen("periph_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open periph_cases.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) != 0) begin
                    n = $sscanf(line_buf, "%h %h %h %h %h %h",
                                op, addr, wdata, expv, host, errf);
                    if (n == 6) begin  // Comment and blank lines fall through
                        run_case(op, addr, wdata, expv, host, errf);
                        cases_run = cases_run + 1;
                    end
                end
            end
            $fclose(fd);
            if (cases_run == 0) begin
                $display("No cases found in periph_cases.txt");
                errors = errors + 1;
            end
        end
        $display("Cases run: %0d, checks: %0d, errors: %0d", cases_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- periph_cases.txt
# Columns in hex: op addr wdata expect host_char err_expected
# op 0 write, 1 read, 2 wait mtip==expect (wdata=timeout), 3 time read, 4 write time+wdata, 5 hold mtip, 6 msip
5 00000000 00000004 00000000 00 0
0 10000000 00000048 00000000 00 0
0 10000000 00000069 00000000 00 0
1 10000008 00000000 00000002 00 0
0 10000000 0000010A 00000000 00 0
1 10000008 00000000 00000003 00 0
1 10000004 00000000 0000005A 5A 0
1 10000004 00000000 000000C3 C3 0
0 1000000C DEADBEEF 00000000 00 0
1 1000000C 00000000 DEADBEEF 00 0
1 10000010 00000000 00000000 00 0
0 30000000 12345678 00000000 00 1
1 30000000 00000000 00000000 00 1
0 02000000 00000001 00000000 00 0
6 00000000 00000000 00000001 00 0
1 02000000 00000000 00000001 00 0
0 02000000 00000000 00000000 00 0
6 00000000 00000000 00000000 00 0
1 02000000 00000000 00000000 00 0
3 0200BFF8 00000000 00000000 00 0
3 0200BFF8 00000000 00000000 00 0
0 02004004 00000000 00000000 00 0
0 02004000 00100000 00000000 00 0
5 00000000 0000001E 00000000 00 0
3 0200BFF8 00000000 00000000 00 0
4 02004000 00000014 00000000 00 0
2 00000000 00000040 00000001 00 0
0 02004000 FFFFFFFF 00000000 00 0
0 02004004 FFFFFFFF 00000000 00 0
2 00000000 00000008 00000000 00 0
1 02004004 00000000 FFFFFFFF 00 0

//--- flist.f
soc_pkg.sv
wb_if.sv
periph_bus.sv
sim_uart.sv
clint_timer.sv
periph_top.sv
tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_top

sources:
  - soc_pkg.sv
  - wb_if.sv
  - periph_bus.sv
  - sim_uart.sv
  - clint_timer.sv
  - periph_top.sv
  - target: simulation
    files:
      - tb_periph_top.sv
